/* logic/imd_isa_pkg.sv */
package imd_isa_pkg;

	// Operations decoded for the multiply/divide unit.
	typedef enum logic [3:0]
	{
		// No operation for the unit.
		NOP   = 4'd0,
		// Move from HI or LO into the destination register.
		MFHI  = 4'd1,
		MFLO  = 4'd2,
		// Move a register into HI or LO.
		MTHI  = 4'd3,
		MTLO  = 4'd4,
		// Multiply, signed and unsigned.
		MULT  = 4'd5,
		MULTU = 4'd6,
		// Divide, signed and unsigned.
		DIV   = 4'd7,
		DIVU  = 4'd8
	} imd_op_t;

endpackage

/* logic/imd_cfg_pkg.sv */
package imd_cfg_pkg;

	// Default general register width.
	parameter int REG_WIDTH = 32;

	// Width of the HI/LO pair and of double results.
	function automatic int hilo_width(input int w);
		return 2 * w;
	endfunction

	// Width of an engine step counter.
	function automatic int cnt_width(input int w);
		return $clog2(w + 1);
	endfunction

endpackage

/* logic/long_imul.sv */
module long_imul #(
	parameter int p_width = 32
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_start,
	input  logic                                         i_signed,
	input  logic [p_width-1:0]                           i_a,
	input  logic [p_width-1:0]                           i_b,
	output logic                                         o_ready,
	output logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  o_product
);

	localparam int CW = imd_cfg_pkg::cnt_width(p_width);

	// Steps left, zero means sign fix.
	logic [CW-1:0]      cnt;
	// Result is negative.
	logic               neg;
	logic [p_width-1:0] mcand;
	logic [p_width-1:0] a_mag;
	logic [p_width-1:0] b_mag;
	// Upper half plus one carry bit.
	logic [p_width:0]   sum;

	assign a_mag = (i_signed && i_a[p_width-1]) ? -i_a : i_a;
	assign b_mag = (i_signed && i_b[p_width-1]) ? -i_b : i_b;
	assign sum = {1'b0, o_product[2*p_width-1:p_width]} +
		(o_product[0] ? {1'b0, mcand} : {(p_width+1){1'b0}});

	// Step control.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_ready <= 1'b1;
			cnt <= '0;
			neg <= 1'b0;
		end
		else if (i_start)
		begin
			o_ready <= 1'b0;
			cnt <= CW'(p_width);
			neg <= i_signed && (i_a[p_width-1] ^ i_b[p_width-1]);
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else
				o_ready <= 1'b1;
		end
	end

	// Multiplier sits in the low half and shifts out.
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			mcand <= a_mag;
			o_product <= {{p_width{1'b0}}, b_mag};
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
				o_product <= {sum, o_product[p_width-1:1]};
			else if (neg)
				o_product <= -o_product;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!nrst)
		i_start |-> o_ready);

endmodule

/* logic/long_idiv.sv */
module long_idiv #(
	parameter int p_width = 32
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_start,
	input  logic                                         i_signed,
	input  logic [p_width-1:0]                           i_dividend,
	input  logic [p_width-1:0]                           i_divisor,
	output logic                                         o_ready,
	output logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  o_remquot
);

	localparam int CW = imd_cfg_pkg::cnt_width(p_width);

	// Steps left, zero means sign fix.
	logic [CW-1:0]      cnt;
	// Quotient and remainder signs.
	logic               neg_q;
	logic               neg_r;
	logic [p_width-1:0] dvs;
	logic [p_width-1:0] dvd_mag;
	logic [p_width-1:0] dvs_mag;
	// Partial remainder and shifting quotient.
	logic [p_width-1:0] rem;
	logic [p_width-1:0] quo;
	// Trial subtract, top bit is the borrow.
	logic [p_width+1:0] diff;

	assign dvd_mag = (i_signed && i_dividend[p_width-1]) ? -i_dividend : i_dividend;
	assign dvs_mag = (i_signed && i_divisor[p_width-1]) ? -i_divisor : i_divisor;
	assign rem = o_remquot[2*p_width-1:p_width];
	assign quo = o_remquot[p_width-1:0];
	assign diff = {1'b0, rem, quo[p_width-1]} - {2'b00, dvs};

	// Step control.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_ready <= 1'b1;
			cnt <= '0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
		end
		else if (i_start)
		begin
			o_ready <= 1'b0;
			cnt <= CW'(p_width);
			// Zero divisor keeps an all ones quotient.
			neg_q <= i_signed && (i_dividend[p_width-1] ^ i_divisor[p_width-1]) &&
				(i_divisor != '0);
			neg_r <= i_signed && i_dividend[p_width-1];
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else
				o_ready <= 1'b1;
		end
	end

	// Dividend enters the quotient half and shifts into the remainder.
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			dvs <= dvs_mag;
			o_remquot <= {{p_width{1'b0}}, dvd_mag};
		end
		else if (!o_ready)
		begin
			if (cnt != '0)
			begin
				// Restore on borrow.
				if (!diff[p_width+1])
					o_remquot <= {diff[p_width-1:0], quo[p_width-2:0], 1'b1};
				else
					o_remquot <= {rem[p_width-2:0], quo[p_width-1], quo[p_width-2:0], 1'b0};
			end
			else
				o_remquot <= {neg_r ? -rem : rem, neg_q ? -quo : quo};
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!nrst)
		i_start |-> o_ready);

endmodule

/* logic/imd_hilo.sv */
module imd_hilo #(
	parameter int p_width = 32
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  logic                                         i_core_stall,
	input  logic                                         i_nullify_mem,
	input  logic                                         i_nullify_wb,
	input  logic                                         i_mt_hi,
	input  logic                                         i_mt_lo,
	input  logic [p_width-1:0]                           i_mt_val,
	input  logic                                         i_load,
	input  logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  i_load_val,
	output logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  o_hilo
);

	// Memory stage copy of a pending move.
	logic               mt_hi_m;
	logic               mt_lo_m;
	logic [p_width-1:0] mt_val_m;

	// Memory stage flags.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mt_hi_m <= 1'b0;
			mt_lo_m <= 1'b0;
		end
		else if (!i_core_stall)
		begin
			mt_hi_m <= i_mt_hi && !i_nullify_mem;
			mt_lo_m <= i_mt_lo && !i_nullify_mem;
		end
	end

	// Move value follows the flags.
	always_ff @(posedge clk)
	begin
		if (!i_core_stall)
			mt_val_m <= i_mt_val;
	end

	// Writeback, engine result first.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_hilo <= '0;
		else if (i_load && !(mt_hi_m && mt_lo_m))
			o_hilo <= i_load_val;
		else if (!i_core_stall && !i_nullify_wb)
		begin
			if (mt_hi_m)
				o_hilo[2*p_width-1:p_width] <= mt_val_m;
			if (mt_lo_m)
				o_hilo[p_width-1:0] <= mt_val_m;
		end
	end

	// A load never meets a held double move.
	a_load_move: assert property (@(posedge clk) disable iff (!nrst)
		!(i_load && i_core_stall && mt_hi_m && mt_lo_m));

endmodule

/* logic/imd_ctrl.sv */
module imd_ctrl #(
	parameter int p_width = 32
) (
	input  logic                                         clk,
	input  logic                                         nrst,
	input  imd_isa_pkg::imd_op_t                         i_op,
	input  logic [p_width-1:0]                           i_rs_val,
	input  logic [p_width-1:0]                           i_rt_val,
	input  logic                                         i_mem_stall,
	input  logic                                         i_fetch_stall,
	input  logic                                         i_nullify_exec,
	input  logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  i_hilo,
	input  logic                                         i_mul_ready,
	input  logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  i_mul_product,
	input  logic                                         i_div_ready,
	input  logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  i_div_remquot,
	output logic                                         o_exec_stall,
	output logic [p_width-1:0]                           o_rs,
	output logic [p_width-1:0]                           o_rt,
	output logic                                         o_signed,
	output logic                                         o_mul_start,
	output logic                                         o_div_start,
	output logic                                         o_mt_hi,
	output logic                                         o_mt_lo,
	output logic [p_width-1:0]                           o_mt_val,
	output logic                                         o_core_stall,
	output logic                                         o_load,
	output logic [imd_cfg_pkg::hilo_width(p_width)-1:0]  o_load_val,
	output logic [p_width-1:0]                           o_rd_val,
	output logic                                         o_rd_valid
);

	// Engine in flight.
	logic mul_busy;
	logic div_busy;
	// Engine finished this cycle.
	logic mul_done;
	logic div_done;
	// Operation needs an idle engine.
	logic interlock;
	// Operation taken by execute.
	logic accept;

	assign interlock = (i_op == imd_isa_pkg::MFHI) || (i_op == imd_isa_pkg::MFLO) ||
		(i_op == imd_isa_pkg::MULT) || (i_op == imd_isa_pkg::MULTU) ||
		(i_op == imd_isa_pkg::DIV) || (i_op == imd_isa_pkg::DIVU);

	// Hold execute only when nothing else stalls the core.
	assign o_exec_stall = !i_mem_stall && !i_fetch_stall && interlock && (mul_busy || div_busy);
	assign o_core_stall = o_exec_stall || i_mem_stall || i_fetch_stall;
	assign accept = !o_core_stall && !i_nullify_exec;

	// Ready is still high in the start cycle, so mask it.
	assign mul_done = mul_busy && i_mul_ready && !o_mul_start;
	assign div_done = div_busy && i_div_ready && !o_div_start;
	assign o_load = mul_done || div_done;
	assign o_load_val = mul_done ? i_mul_product : i_div_remquot;

	// Execute stage control.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_mt_hi <= 1'b0;
			o_mt_lo <= 1'b0;
			o_rd_valid <= 1'b0;
			o_signed <= 1'b0;
			o_mul_start <= 1'b0;
			o_div_start <= 1'b0;
			mul_busy <= 1'b0;
			div_busy <= 1'b0;
		end
		else
		begin
			// Starts are single pulses.
			o_mul_start <= 1'b0;
			o_div_start <= 1'b0;
			if (mul_done)
				mul_busy <= 1'b0;
			if (div_done)
				div_busy <= 1'b0;
			// Stage drains on every free edge.
			if (!o_core_stall)
			begin
				o_mt_hi <= 1'b0;
				o_mt_lo <= 1'b0;
				o_rd_valid <= 1'b0;
			end
			if (accept)
			begin
				case (i_op)
					imd_isa_pkg::MFHI, imd_isa_pkg::MFLO: o_rd_valid <= 1'b1;
					imd_isa_pkg::MTHI: o_mt_hi <= 1'b1;
					imd_isa_pkg::MTLO: o_mt_lo <= 1'b1;
					imd_isa_pkg::MULT, imd_isa_pkg::MULTU:
					begin
						o_signed <= (i_op == imd_isa_pkg::MULT);
						o_mul_start <= 1'b1;
						mul_busy <= 1'b1;
					end
					imd_isa_pkg::DIV, imd_isa_pkg::DIVU:
					begin
						o_signed <= (i_op == imd_isa_pkg::DIV);
						o_div_start <= 1'b1;
						div_busy <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Operands and results.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			case (i_op)
				imd_isa_pkg::MFHI: o_rd_val <= i_hilo[2*p_width-1:p_width];
				imd_isa_pkg::MFLO: o_rd_val <= i_hilo[p_width-1:0];
				imd_isa_pkg::MTHI, imd_isa_pkg::MTLO: o_mt_val <= i_rs_val;
				imd_isa_pkg::MULT, imd_isa_pkg::MULTU, imd_isa_pkg::DIV, imd_isa_pkg::DIVU:
				begin
					o_rs <= i_rs_val;
					o_rt <= i_rt_val;
				end
				default: ;
			endcase
		end
	end

	// Interlock keeps the engines exclusive.
	a_one_busy: assert property (@(posedge clk) disable iff (!nrst)
		!(mul_busy && div_busy));
	// Starts only reach idle engines.
	a_mul_start: assert property (@(posedge clk) disable iff (!nrst)
		o_mul_start |-> i_mul_ready);
	a_div_start: assert property (@(posedge clk) disable iff (!nrst)
		o_div_start |-> i_div_ready);

endmodule

/* logic/imd_unit.sv */
module imd_unit #(
	parameter int p_width = imd_cfg_pkg::REG_WIDTH
) (
	input  logic                 clk,
	input  logic                 nrst,
	input  imd_isa_pkg::imd_op_t i_op,
	input  logic [p_width-1:0]   i_rs_val,
	input  logic [p_width-1:0]   i_rt_val,
	input  logic                 i_mem_stall,
	input  logic                 i_fetch_stall,
	input  logic                 i_nullify_exec,
	input  logic                 i_nullify_mem,
	input  logic                 i_nullify_wb,
	output logic                 o_exec_stall,
	output logic [p_width-1:0]   o_rd_val,
	output logic                 o_rd_valid
);

	localparam int HW = imd_cfg_pkg::hilo_width(p_width);

	// Engine operands and handshake.
	logic [p_width-1:0] rs;
	logic [p_width-1:0] rt;
	logic               signed_op;
	logic               mul_start;
	logic               div_start;
	logic               mul_ready;
	logic               div_ready;
	logic [HW-1:0]      mul_product;
	logic [HW-1:0]      div_remquot;
	// Move pipeline and HI/LO.
	logic               mt_hi;
	logic               mt_lo;
	logic [p_width-1:0] mt_val;
	logic               core_stall;
	logic               load;
	logic [HW-1:0]      load_val;
	logic [HW-1:0]      hilo;

	imd_ctrl #(.p_width(p_width)) u_ctrl (
		.clk(clk), .nrst(nrst), .i_op(i_op), .i_rs_val(i_rs_val), .i_rt_val(i_rt_val),
		.i_mem_stall(i_mem_stall), .i_fetch_stall(i_fetch_stall),
		.i_nullify_exec(i_nullify_exec), .i_hilo(hilo),
		.i_mul_ready(mul_ready), .i_mul_product(mul_product),
		.i_div_ready(div_ready), .i_div_remquot(div_remquot),
		.o_exec_stall(o_exec_stall), .o_rs(rs), .o_rt(rt), .o_signed(signed_op),
		.o_mul_start(mul_start), .o_div_start(div_start),
		.o_mt_hi(mt_hi), .o_mt_lo(mt_lo), .o_mt_val(mt_val), .o_core_stall(core_stall),
		.o_load(load), .o_load_val(load_val), .o_rd_val(o_rd_val), .o_rd_valid(o_rd_valid)
	);

	imd_hilo #(.p_width(p_width)) u_hilo (
		.clk(clk), .nrst(nrst), .i_core_stall(core_stall),
		.i_nullify_mem(i_nullify_mem), .i_nullify_wb(i_nullify_wb),
		.i_mt_hi(mt_hi), .i_mt_lo(mt_lo), .i_mt_val(mt_val),
		.i_load(load), .i_load_val(load_val), .o_hilo(hilo)
	);

	long_imul #(.p_width(p_width)) u_imul (
		.clk(clk), .nrst(nrst), .i_start(mul_start), .i_signed(signed_op),
		.i_a(rs), .i_b(rt), .o_ready(mul_ready), .o_product(mul_product)
	);

	long_idiv #(.p_width(p_width)) u_idiv (
		.clk(clk), .nrst(nrst), .i_start(div_start), .i_signed(signed_op),
		.i_dividend(rs), .i_divisor(rt), .o_ready(div_ready), .o_remquot(div_remquot)
	);

endmodule

/* test/tb_clk_gen.sv */
module tb_clk_gen (
	output logic o_clk,
	output logic o_nrst
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free running clock, 10 ns period.
	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// Reset held for the first 16 rising edges.
	initial
	begin
		o_nrst = 1'b0;
		repeat (16) @(posedge o_clk);
		o_nrst <= 1'b1;
	end

endmodule

/* test/tb_imd_unit.sv */
module tb_imd_unit;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int W = imd_cfg_pkg::REG_WIDTH;
	// Roughly 60 engine operations at up to 40 cycles each.
	localparam int MAX_CYCLES = 3000;

	logic                 clk;
	logic                 nrst;
	imd_isa_pkg::imd_op_t i_op;
	logic [W-1:0]         i_rs_val;
	logic [W-1:0]         i_rt_val;
	logic                 i_mem_stall;
	logic                 i_fetch_stall;
	logic                 i_nullify_exec;
	logic                 i_nullify_mem;
	logic                 i_nullify_wb;
	logic                 o_exec_stall;
	logic [W-1:0]         o_rd_val;
	logic                 o_rd_valid;

	// Next rising edge has no stall at all.
	logic                 free_now;
	// Edge conditions, taken at the falling edge before it.
	logic                 s_free;
	logic                 s_acc;
	imd_isa_pkg::imd_op_t s_op;
	logic [W-1:0]         s_rs;
	logic [W-1:0]         s_rt;
	logic                 s_nm;
	logic                 s_nw;
	// Reference HI/LO and the two move stages.
	logic [2*W-1:0]       hilo_m;
	logic                 x_hi;
	logic                 x_lo;
	logic [W-1:0]         x_val;
	logic                 m_hi;
	logic                 m_lo;
	logic [W-1:0]         m_val;
	// Expected move-from result.
	logic                 exp_rd_valid;
	logic [W-1:0]         exp_rd_val;
	int                   seed;
	int                   cycles = 0;

	tb_clk_gen u_clk_gen (.o_clk(clk), .o_nrst(nrst));

	imd_unit #(.p_width(W)) u_imd_unit (
		.clk(clk), .nrst(nrst), .i_op(i_op), .i_rs_val(i_rs_val), .i_rt_val(i_rt_val),
		.i_mem_stall(i_mem_stall), .i_fetch_stall(i_fetch_stall),
		.i_nullify_exec(i_nullify_exec), .i_nullify_mem(i_nullify_mem),
		.i_nullify_wb(i_nullify_wb), .o_exec_stall(o_exec_stall),
		.o_rd_val(o_rd_val), .o_rd_valid(o_rd_valid)
	);

	assign free_now = !o_exec_stall && !i_mem_stall && !i_fetch_stall;

	task automatic report_plain(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic report_value(input string name, input logic [W-1:0] exp_v,
		input logic [W-1:0] act_v);
		report_plain($sformatf("ERROR %s expected %h actual %h", name, exp_v, act_v));
	endtask

	// Two's complement product on sign or zero extended operands.
	function automatic logic [2*W-1:0] mul_ref(input logic [W-1:0] a, input logic [W-1:0] b,
		input logic sgn);
		logic [2*W-1:0] ax;
		logic [2*W-1:0] bx;
		ax = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
		bx = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
		return ax * bx;
	endfunction

	// Truncating division, remainder follows the dividend sign.
	function automatic logic [2*W-1:0] div_ref(input logic [W-1:0] a, input logic [W-1:0] b,
		input logic sgn);
		logic [W-1:0] am;
		logic [W-1:0] bm;
		logic [W-1:0] q;
		logic [W-1:0] r;
		am = (sgn && a[W-1]) ? -a : a;
		bm = (sgn && b[W-1]) ? -b : b;
		if (b == '0)
			return {a, {W{1'b1}}};
		q = am / bm;
		r = am % bm;
		if (sgn && (a[W-1] ^ b[W-1]))
			q = -q;
		if (sgn && a[W-1])
			r = -r;
		return {r, q};
	endfunction

	// Drive one operation and return on the edge that takes it.
	task automatic issue_ctl(input imd_isa_pkg::imd_op_t op, input logic [W-1:0] a,
		input logic [W-1:0] b, input logic nx, input logic nm, input logic nw);
		i_op <= op;
		i_rs_val <= a;
		i_rt_val <= b;
		i_nullify_exec <= nx;
		i_nullify_mem <= nm;
		i_nullify_wb <= nw;
		do
			@(negedge clk);
		while (!free_now);
		@(posedge clk);
	endtask

	task automatic issue(input imd_isa_pkg::imd_op_t op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		issue_ctl(op, a, b, 1'b0, 1'b0, 1'b0);
	endtask

	// Memory stall for n edges with op waiting in execute.
	task automatic hold_mem(input imd_isa_pkg::imd_op_t op, input int n);
		i_op <= op;
		i_mem_stall <= 1'b1;
		repeat (n) @(posedge clk);
		i_mem_stall <= 1'b0;
	endtask

	// Move to, two spacers, then move from.
	task automatic move_check(input logic to_hi, input logic [W-1:0] v);
		if (to_hi)
			issue(imd_isa_pkg::MTHI, v, '0);
		else
			issue(imd_isa_pkg::MTLO, v, '0);
		issue(imd_isa_pkg::NOP, '0, '0);
		issue(imd_isa_pkg::NOP, '0, '0);
		if (to_hi)
			issue(imd_isa_pkg::MFHI, '0, '0);
		else
			issue(imd_isa_pkg::MFLO, '0, '0);
	endtask

	// Engine operation read back through both halves.
	task automatic engine_check(input imd_isa_pkg::imd_op_t op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		issue(op, a, b);
		issue(imd_isa_pkg::MFLO, '0, '0);
		issue(imd_isa_pkg::MFHI, '0, '0);
	endtask

	always @(negedge clk)
	begin
		s_free = free_now;
		s_acc = free_now && !i_nullify_exec;
		s_op = i_op;
		s_rs = i_rs_val;
		s_rt = i_rt_val;
		s_nm = i_nullify_mem;
		s_nw = i_nullify_wb;
	end

	// Reference model, advances only on stall free edges.
	always @(posedge clk)
	begin
		if (!nrst)
		begin
			hilo_m = '0;
			x_hi = 1'b0;
			x_lo = 1'b0;
			m_hi = 1'b0;
			m_lo = 1'b0;
			exp_rd_valid <= 1'b0;
		end
		else if (s_free)
		begin
			// Move-from reads HI/LO as it stood before this edge.
			exp_rd_valid <= s_acc && (s_op == imd_isa_pkg::MFHI || s_op == imd_isa_pkg::MFLO);
			if (s_acc && s_op == imd_isa_pkg::MFHI)
				exp_rd_val <= hilo_m[2*W-1:W];
			if (s_acc && s_op == imd_isa_pkg::MFLO)
				exp_rd_val <= hilo_m[W-1:0];
			// Writeback.
			if (m_hi && !s_nw)
				hilo_m[2*W-1:W] = m_val;
			if (m_lo && !s_nw)
				hilo_m[W-1:0] = m_val;
			m_hi = x_hi && !s_nm;
			m_lo = x_lo && !s_nm;
			m_val = x_val;
			x_hi = s_acc && s_op == imd_isa_pkg::MTHI;
			x_lo = s_acc && s_op == imd_isa_pkg::MTLO;
			if (x_hi || x_lo)
				x_val = s_rs;
			// Engine results land before any later move-from.
			if (s_acc)
			begin
				case (s_op)
					imd_isa_pkg::MULT: hilo_m = mul_ref(s_rs, s_rt, 1'b1);
					imd_isa_pkg::MULTU: hilo_m = mul_ref(s_rs, s_rt, 1'b0);
					imd_isa_pkg::DIV: hilo_m = div_ref(s_rs, s_rt, 1'b1);
					imd_isa_pkg::DIVU: hilo_m = div_ref(s_rs, s_rt, 1'b0);
					default: ;
				endcase
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			report_plain("Timeout, the test sequence did not finish");
	end

	a_reset_idle: assert property (@(posedge clk) !nrst |-> !o_exec_stall && !o_rd_valid)
		else report_plain("Stall or read valid high during reset");
	a_rd_valid: assert property (@(posedge clk) disable iff (!nrst)
		o_rd_valid == exp_rd_valid)
		else report_value("o_rd_valid", $sampled(exp_rd_valid), $sampled(o_rd_valid));
	a_rd_val: assert property (@(posedge clk) disable iff (!nrst)
		o_rd_valid |-> o_rd_val == exp_rd_val)
		else report_value("o_rd_val", $sampled(exp_rd_val), $sampled(o_rd_val));
	a_mem_stall: assert property (@(posedge clk) disable iff (!nrst)
		i_mem_stall |-> !o_exec_stall)
		else report_plain("Execute stall raised during a memory stall");

	initial
	begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] corner [3];
		seed = 50918;
		i_op = imd_isa_pkg::NOP;
		i_rs_val = '0;
		i_rt_val = '0;
		i_mem_stall = 1'b0;
		i_fetch_stall = 1'b0;
		i_nullify_exec = 1'b0;
		i_nullify_mem = 1'b0;
		i_nullify_wb = 1'b0;
		corner[0] = '0;
		corner[1] = {1'b1, {(W-1){1'b0}}};
		corner[2] = '1;
		wait (nrst);
		@(posedge clk);
		// Zero HI/LO after reset.
		issue(imd_isa_pkg::MFHI, '0, '0);
		issue(imd_isa_pkg::MFLO, '0, '0);
		repeat (2)
		begin
			move_check(1'b1, $random(seed));
			move_check(1'b0, $random(seed));
		end
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				engine_check(imd_isa_pkg::MULT, corner[i], corner[j]);
				engine_check(imd_isa_pkg::MULTU, corner[i], corner[j]);
			end
		end
		// Zero divisor, overflow case and mixed signs.
		engine_check(imd_isa_pkg::DIV, W'(-7), '0);
		engine_check(imd_isa_pkg::DIVU, W'(-7), '0);
		engine_check(imd_isa_pkg::DIV, corner[1], corner[2]);
		engine_check(imd_isa_pkg::DIV, W'(-7), W'(2));
		engine_check(imd_isa_pkg::DIV, W'(7), W'(-2));
		engine_check(imd_isa_pkg::DIV, W'(-7), W'(-2));
		engine_check(imd_isa_pkg::DIVU, W'(-7), W'(2));
		for (int i = 0; i < 5; i++)
		begin
			a = $random(seed);
			b = $random(seed);
			engine_check(imd_isa_pkg::MULT, a, b);
			engine_check(imd_isa_pkg::MULTU, a, b);
			engine_check(imd_isa_pkg::DIV, a, b >> (4 * i));
			engine_check(imd_isa_pkg::DIVU, a, b >> (4 * i));
		end
		// Killed moves leave HI/LO alone.
		issue(imd_isa_pkg::MTHI, $random(seed), '0);
		issue_ctl(imd_isa_pkg::NOP, '0, '0, 1'b0, 1'b1, 1'b0);
		issue(imd_isa_pkg::NOP, '0, '0);
		issue(imd_isa_pkg::MFHI, '0, '0);
		issue(imd_isa_pkg::MTLO, $random(seed), '0);
		issue(imd_isa_pkg::NOP, '0, '0);
		issue_ctl(imd_isa_pkg::NOP, '0, '0, 1'b0, 1'b0, 1'b1);
		issue(imd_isa_pkg::MFLO, '0, '0);
		// Nullified move-from gives no pulse.
		issue_ctl(imd_isa_pkg::MFHI, '0, '0, 1'b1, 1'b0, 1'b0);
		issue(imd_isa_pkg::NOP, '0, '0);
		// Memory stall over a pending move and over running engines.
		issue(imd_isa_pkg::MTLO, $random(seed), '0);
		hold_mem(imd_isa_pkg::NOP, 5);
		issue(imd_isa_pkg::NOP, '0, '0);
		issue(imd_isa_pkg::NOP, '0, '0);
		issue(imd_isa_pkg::MFLO, '0, '0);
		issue(imd_isa_pkg::DIV, $random(seed), $random(seed) >> 8);
		hold_mem(imd_isa_pkg::MFLO, 6);
		issue(imd_isa_pkg::MFLO, '0, '0);
		issue(imd_isa_pkg::MFHI, '0, '0);
		issue(imd_isa_pkg::MULT, $random(seed), $random(seed));
		hold_mem(imd_isa_pkg::MFHI, 40);
		issue(imd_isa_pkg::MFHI, '0, '0);
		issue(imd_isa_pkg::MFLO, '0, '0);
		issue(imd_isa_pkg::NOP, '0, '0);
		repeat (2) @(posedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* src.f */
logic/imd_isa_pkg.sv
logic/imd_cfg_pkg.sv
logic/long_imul.sv
logic/long_idiv.sv
logic/imd_hilo.sv
logic/imd_ctrl.sv
logic/imd_unit.sv
test/tb_clk_gen.sv
test/tb_imd_unit.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_imd_unit -f src.f \
	&& ./obj_dir/Vtb_imd_unit \
	|| exit 1
